//--- common/vec_cfg_pkg.sv
package vec_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Vector geometry
    //////////////////////////////////////////////////////////////////////

    parameter int VLEN            = 128;
    parameter int SLICE_W         = 32;
    parameter int SLICES_PER_LANE = VLEN / SLICE_W;
    parameter int MAX_REGS        = 4;

    typedef logic [VLEN-1:0] vreg_t;

    // Register 0 sits in the low bits
    typedef vreg_t [MAX_REGS-1:0] vreg_group_t;

    typedef logic [$clog2(MAX_REGS)-1:0] reg_idx_t;

    // Both encoded as log2 of the count
    typedef enum logic [1:0] {
        LANES_1 = 2'd0,
        LANES_2 = 2'd1,
        LANES_4 = 2'd2
    } lanes_t;

    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } lmul_t;

endpackage

//--- common/valu_pkg.sv
package valu_pkg;

    //////////////////////////////////////////////////////////////////////
    // ALU opcodes and element widths
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_MINU = 4'd5,
        OP_MAXU = 4'd6
    } alu_op_t;

    // Element width per slice
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_t;

endpackage

//--- common/issue_if.sv
`timescale 1ns/100ps

interface issue_if #(
    parameter int NUM_LANES = 4
);
    import vec_cfg_pkg::*;
    import valu_pkg::*;

    logic                  valid;
    alu_op_t               opcode;
    sew_t                  sew;
    logic [NUM_LANES-1:0]  lane_en;
    vreg_t [NUM_LANES-1:0] op_a;
    vreg_t [NUM_LANES-1:0] op_b;
    // Group index of the register on lane 0
    reg_idx_t              base_reg;
    logic                  last;

    modport issue (
        output valid, opcode, sew, lane_en, op_a, op_b, base_reg, last
    );

    modport lanes (
        input valid, opcode, sew, lane_en, op_a, op_b, base_reg, last
    );

endinterface

//--- common/lane_result_if.sv
`timescale 1ns/100ps

interface lane_result_if #(
    parameter int NUM_LANES = 4
);
    import vec_cfg_pkg::*;

    logic                  valid;
    logic [NUM_LANES-1:0]  lane_en;
    // One result register per lane
    vreg_t [NUM_LANES-1:0] data;
    reg_idx_t              base_reg;
    logic                  last;

    modport lanes (
        output valid, lane_en, data, base_reg, last
    );

    modport collect (
        input valid, lane_en, data, base_reg, last
    );

endinterface

//--- src/issue_sequencer.sv
`timescale 1ns/100ps

module issue_sequencer #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     start,
    input  valu_pkg::alu_op_t        opcode,
    input  valu_pkg::sew_t           sew,
    input  vec_cfg_pkg::lmul_t       lmul,
    input  vec_cfg_pkg::lanes_t      lanes,
    input  vec_cfg_pkg::vreg_group_t op_a,
    input  vec_cfg_pkg::vreg_group_t op_b,
    output logic                     busy,
    issue_if.issue                   issue
);
    import vec_cfg_pkg::*;
    import valu_pkg::*;

    localparam int LANE_LOG_MAX = $clog2(NUM_LANES);

    typedef enum logic {IDLE, ISSUE} state_t;

    state_t               state;
    vreg_group_t          a_q;
    vreg_group_t          b_q;
    alu_op_t              op_q;
    sew_t                 sew_q;
    logic                 accept;
    logic [1:0]           lane_log;
    logic [1:0]           pass_log;
    logic [1:0]           lane_log_q;
    logic [2:0]           nregs_q;
    logic [2:0]           base_wide;
    logic [2:0]           lane_cnt;
    reg_idx_t             pass_cnt;
    reg_idx_t             pass_last;
    reg_idx_t             base_q;
    logic [NUM_LANES-1:0] en_next;
    logic [NUM_LANES-1:0] lane_en_q;
    logic                 valid_q;
    logic                 last_q;
    logic                 drain;

    assign accept = start && !busy;

    // Clamp the lane request to the physical lanes
    always_comb begin
        if (int'(lanes) > LANE_LOG_MAX) begin
            lane_log = 2'(LANE_LOG_MAX);
        end else begin
            lane_log = lanes;
        end
        pass_log = (2'(lmul) > lane_log) ? 2'(lmul) - lane_log : 2'd0;
    end

    //////////////////////////////////////////////////////////////////////
    // Pass stepping
    //////////////////////////////////////////////////////////////////////

    assign base_wide = 3'(pass_cnt) << lane_log_q;
    assign lane_cnt  = 3'd1 << lane_log_q;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            en_next[i] = (i < lane_cnt) && ((int'(base_wide) + i) < int'(nregs_q));
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= IDLE;
            busy       <= 1'b0;
            drain      <= 1'b0;
            pass_cnt   <= '0;
            pass_last  <= '0;
            lane_log_q <= '0;
            nregs_q    <= '0;
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            base_q     <= '0;
            lane_en_q  <= '0;
        end else begin
            drain   <= valid_q && last_q;
            valid_q <= (state == ISSUE);
            last_q  <= (state == ISSUE) && (pass_cnt == pass_last);
            if (accept) begin
                state      <= ISSUE;
                busy       <= 1'b1;
                pass_cnt   <= '0;
                pass_last  <= reg_idx_t'((3'd1 << pass_log) - 3'd1);
                lane_log_q <= lane_log;
                nregs_q    <= 3'd1 << 2'(lmul);
            end else if (drain) begin
                // Last pass has reached the collector
                busy <= 1'b0;
            end
            if (state == ISSUE) begin
                base_q    <= base_wide[1:0];
                lane_en_q <= en_next;
                pass_cnt  <= pass_cnt + 1'b1;
                if (pass_cnt == pass_last) begin
                    state <= IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q   <= op_a;
            b_q   <= op_b;
            op_q  <= opcode;
            sew_q <= sew;
        end
    end

    // Operand select per lane from the registered pass base
    always_comb begin
        reg_idx_t idx;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = base_q + reg_idx_t'(i);
            issue.op_a[i] = a_q[idx];
            issue.op_b[i] = b_q[idx];
        end
    end

    assign issue.valid    = valid_q;
    assign issue.last     = last_q;
    assign issue.base_reg = base_q;
    assign issue.lane_en  = lane_en_q;
    assign issue.opcode   = op_q;
    assign issue.sew      = sew_q;

    // First pass leaves one edge after a start taken from IDLE
    a_no_valid_idle: assert property (@(posedge clk) disable iff (!nrst)
        $rose(issue.valid) |-> $past(accept && (state == IDLE), 2));

endmodule

//--- lanes/valu_slice.sv
`timescale 1ns/100ps

module valu_slice (
    input  logic              clk,
    input  logic              nrst,
    input  logic              en,
    input  valu_pkg::alu_op_t opcode,
    input  valu_pkg::sew_t    sew,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result
);
    import valu_pkg::*;

    logic [31:0] res_8;
    logic [31:0] res_16;
    logic [31:0] res_32;
    logic [31:0] alu_out;

    // Element op on zero-extended operands
    function automatic logic [31:0] elem_op(
        input alu_op_t     op,
        input logic [31:0] x,
        input logic [31:0] y
    );
        logic [31:0] r;
        case (op)
            OP_ADD:  r = x + y;
            OP_SUB:  r = x - y;
            OP_AND:  r = x & y;
            OP_OR:   r = x | y;
            OP_XOR:  r = x ^ y;
            OP_MINU: r = (x < y) ? x : y;
            OP_MAXU: r = (x > y) ? x : y;
            default: r = '0;
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Per-width lanes, carry cut at each element boundary
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int e = 0; e < 4; e++) begin
            res_8[8*e +: 8] = 8'(elem_op(opcode, 32'(a[8*e +: 8]), 32'(b[8*e +: 8])));
        end
        for (int e = 0; e < 2; e++) begin
            res_16[16*e +: 16] =
                16'(elem_op(opcode, 32'(a[16*e +: 16]), 32'(b[16*e +: 16])));
        end
        res_32 = elem_op(opcode, a, b);
    end

    always_comb begin
        case (sew)
            SEW_8:   alu_out = res_8;
            SEW_16:  alu_out = res_16;
            SEW_32:  alu_out = res_32;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result <= '0;
        end else if (en) begin
            result <= alu_out;
        end
    end

    a_sew_legal: assert property (@(posedge clk) disable iff (!nrst)
        en |-> (sew inside {SEW_8, SEW_16, SEW_32}));

endmodule

//--- lanes/lane_array.sv
`timescale 1ns/100ps

module lane_array #(
    parameter int NUM_LANES = 4
) (
    input  logic         clk,
    input  logic         nrst,
    issue_if.lanes       issue,
    lane_result_if.lanes res
);
    import vec_cfg_pkg::*;

    logic [SLICE_W-1:0]   slice_res [NUM_LANES][SLICES_PER_LANE];
    logic [NUM_LANES-1:0] lane_go;

    // Clock enable per lane
    assign lane_go = issue.lane_en & {NUM_LANES{issue.valid}};

    //////////////////////////////////////////////////////////////////////
    // Lane by slice ALU array
    //////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        for (genvar s = 0; s < SLICES_PER_LANE; s++) begin : g_slice
            valu_slice u_slice (
                .clk    (clk),
                .nrst   (nrst),
                .en     (lane_go[l]),
                .opcode (issue.opcode),
                .sew    (issue.sew),
                .a      (issue.op_a[l][s*SLICE_W +: SLICE_W]),
                .b      (issue.op_b[l][s*SLICE_W +: SLICE_W]),
                .result (slice_res[l][s])
            );
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int s = 0; s < SLICES_PER_LANE; s++) begin
                res.data[l][s*SLICE_W +: SLICE_W] = slice_res[l][s];
            end
        end
    end

    // Tags delayed to match the slice register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            res.valid    <= 1'b0;
            res.lane_en  <= '0;
            res.base_reg <= '0;
            res.last     <= 1'b0;
        end else begin
            res.valid    <= issue.valid;
            res.lane_en  <= issue.lane_en;
            res.base_reg <= issue.base_reg;
            res.last     <= issue.last;
        end
    end

endmodule

//--- src/result_collector.sv
`timescale 1ns/100ps

module result_collector #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     clear,
    lane_result_if.collect           res,
    output vec_cfg_pkg::vreg_group_t result,
    output logic                     done
);
    import vec_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Result registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= res.valid && res.last;
            if (clear) begin
                // New request wipes the whole group
                result <= '0;
            end else if (res.valid) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (res.lane_en[i] && ((int'(res.base_reg) + i) < MAX_REGS)) begin
                        result[int'(res.base_reg) + i] <= res.data[i];
                    end
                end
            end
        end
    end

    // Sequencer enables must never point past the group
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_chk
        a_reg_range: assert property (@(posedge clk) disable iff (!nrst)
            (res.valid && res.lane_en[i]) |-> ((int'(res.base_reg) + i) < MAX_REGS));
    end

endmodule

//--- src/vec_lanes_top.sv
`timescale 1ns/100ps

module vec_lanes_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     start,
    input  valu_pkg::alu_op_t        opcode,
    input  valu_pkg::sew_t           sew,
    input  vec_cfg_pkg::lmul_t       lmul,
    input  vec_cfg_pkg::lanes_t      lanes,
    input  vec_cfg_pkg::vreg_group_t op_a,
    input  vec_cfg_pkg::vreg_group_t op_b,
    output vec_cfg_pkg::vreg_group_t result,
    output logic                     busy,
    output logic                     done
);

    issue_if #(.NUM_LANES(NUM_LANES)) issue_bus ();
    lane_result_if #(.NUM_LANES(NUM_LANES)) res_bus ();

    //////////////////////////////////////////////////////////////////////
    // Sequencer, lanes and collector
    //////////////////////////////////////////////////////////////////////

    issue_sequencer #(
        .NUM_LANES (NUM_LANES)
    ) u_seq (
        .clk    (clk),
        .nrst   (nrst),
        .start  (start),
        .opcode (opcode),
        .sew    (sew),
        .lmul   (lmul),
        .lanes  (lanes),
        .op_a   (op_a),
        .op_b   (op_b),
        .busy   (busy),
        .issue  (issue_bus.issue)
    );

    lane_array #(
        .NUM_LANES (NUM_LANES)
    ) u_lanes (
        .clk   (clk),
        .nrst  (nrst),
        .issue (issue_bus.lanes),
        .res   (res_bus.lanes)
    );

    // Cleared on the same edge the sequencer takes a start
    result_collector #(
        .NUM_LANES (NUM_LANES)
    ) u_coll (
        .clk    (clk),
        .nrst   (nrst),
        .clear  (start && !busy),
        .res    (res_bus.collect),
        .result (result),
        .done   (done)
    );

endmodule

//--- testbench/tb_vec_lanes.sv
`timescale 1ns/100ps

module tb_vec_lanes;
    import vec_cfg_pkg::*;
    import valu_pkg::*;

    localparam int TEST_BUDGET     = 60;
    localparam int CYCLES_PER_TEST = 8;
    localparam int TIMEOUT_CYCLES  = TEST_BUDGET * CYCLES_PER_TEST;

    logic        clk;
    logic        nrst;
    logic        start;
    alu_op_t     opcode;
    sew_t        sew;
    lmul_t       lmul;
    lanes_t      lanes;
    vreg_group_t op_a;
    vreg_group_t op_b;
    vreg_group_t result;
    logic        busy;
    logic        done;

    logic [31:0] lfsr_state = 32'h416e7dbd;
    int          cycle_cnt  = 0;

    vec_lanes_top #(.NUM_LANES(4)) dut (
        .clk    (clk),
        .nrst   (nrst),
        .start  (start),
        .opcode (opcode),
        .sew    (sew),
        .lmul   (lmul),
        .lanes  (lanes),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus source and reference model
    //////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_group(output vreg_group_t g);
        logic [VLEN*MAX_REGS-1:0] flat;
        for (int i = 0; i < VLEN * MAX_REGS; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            flat[i] = lfsr_state[0];
        end
        g = flat;
    endtask

    function automatic int sew_bits(input sew_t s);
        case (s)
            SEW_8:   return 8;
            SEW_16:  return 16;
            default: return 32;
        endcase
    endfunction

    function automatic int reg_count(input lmul_t m);
        case (m)
            LMUL_1:  return 1;
            LMUL_2:  return 2;
            default: return 4;
        endcase
    endfunction

    function automatic int lane_count(input lanes_t n);
        case (n)
            LANES_1: return 1;
            LANES_2: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic vreg_group_t ref_group(input alu_op_t op, input sew_t s,
                                              input lmul_t m, input vreg_group_t a,
                                              input vreg_group_t b);
        vreg_group_t g;
        int          w;
        logic [31:0] mask;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        g    = '0;
        w    = sew_bits(s);
        mask = (w == 32) ? 32'hFFFF_FFFF : (32'd1 << w) - 32'd1;
        for (int rg = 0; rg < reg_count(m); rg++) begin
            for (int e = 0; e < VLEN / w; e++) begin
                x = 32'(a[rg] >> (e * w)) & mask;
                y = 32'(b[rg] >> (e * w)) & mask;
                case (op)
                    OP_ADD:  r = x + y;
                    OP_SUB:  r = x - y;
                    OP_AND:  r = x & y;
                    OP_OR:   r = x | y;
                    OP_XOR:  r = x ^ y;
                    OP_MINU: r = (x < y) ? x : y;
                    default: r = (x > y) ? x : y;
                endcase
                g[rg] = g[rg] | (vreg_t'(r & mask) << (e * w));
            end
        end
        return g;
    endfunction

    task automatic check_eq(input string name, input logic [511:0] expected,
                            input logic [511:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    // Runs one request and checks done timing, busy and every result register
    task automatic run_op(input alu_op_t op, input sew_t s, input lmul_t m,
                          input lanes_t n, input vreg_group_t a, input vreg_group_t b);
        vreg_group_t expected;
        int          passes;
        int          edges;
        expected = ref_group(op, s, m, a, b);
        passes   = reg_count(m) / lane_count(n);
        if (passes < 1) begin
            passes = 1;
        end
        @(posedge clk);
        #2;
        opcode = op;
        sew    = s;
        lmul   = m;
        lanes  = n;
        op_a   = a;
        op_b   = b;
        start  = 1'b1;
        @(posedge clk);
        #1;
        check_eq("busy", 1, busy);
        #1;
        start = 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
            if (!done) begin
                check_eq("busy", 1, busy);
            end
        end while (!done);
        check_eq("done_edge", passes + 2, edges);
        check_eq("busy", 0, busy);
        for (int r = 0; r < MAX_REGS; r++) begin
            check_eq($sformatf("result[%0d]", r), expected[r], result[r]);
        end
        @(posedge clk);
        #1;
        check_eq("done", 0, done);
    endtask

    task automatic reset_state_check();
        nrst = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        nrst = 1'b1;
        #1;
        check_eq("busy", 0, busy);
        check_eq("done", 0, done);
        check_eq("result", 0, result);
    endtask

    task automatic opcode_sweep();
        vreg_group_t a;
        vreg_group_t b;
        for (int op = 0; op < 7; op++) begin
            for (int s = 0; s < 3; s++) begin
                rand_group(a);
                rand_group(b);
                run_op(alu_op_t'(op), sew_t'(s), LMUL_1, LANES_1, a, b);
            end
        end
    endtask

    task automatic geometry_sweep();
        vreg_group_t a;
        vreg_group_t b;
        for (int n = 0; n < 3; n++) begin
            for (int m = 2; m >= 0; m--) begin
                rand_group(a);
                rand_group(b);
                run_op(alu_op_t'((n * 3 + m) % 7), sew_t'((n + m) % 3), lmul_t'(m),
                       lanes_t'(n), a, b);
            end
        end
    endtask

    task automatic carry_case(input alu_op_t op, input sew_t s, input vreg_t a_reg,
                              input vreg_t b_reg, input vreg_t expected);
        run_op(op, s, LMUL_1, LANES_1, {4{a_reg}}, {4{b_reg}});
        check_eq("result[0]", expected, result[0]);
    endtask

    task automatic carry_cut_checks();
        carry_case(OP_ADD, SEW_8, {8{16'h20FF}}, {8{16'h0001}}, {8{16'h2000}});
        carry_case(OP_SUB, SEW_16, {4{32'h0005_0000}}, {4{32'h0000_0001}},
                   {4{32'h0005_FFFF}});
        carry_case(OP_SUB, SEW_32, {2{64'h0000_0007_0000_0000}},
                   {2{64'h0000_0000_0000_0001}}, {2{64'h0000_0007_FFFF_FFFF}});
        carry_case(OP_MINU, SEW_16, {4{32'h8000_0001}}, {4{32'h7FFF_FFFF}},
                   {4{32'h7FFF_0001}});
        carry_case(OP_MAXU, SEW_16, {4{32'h8000_0001}}, {4{32'h7FFF_FFFF}},
                   {4{32'h8000_FFFF}});
        carry_case(OP_MINU, SEW_32, {2{64'h8000_0000_0000_0001}},
                   {2{64'h7FFF_FFFF_FFFF_FFFF}}, {2{64'h7FFF_FFFF_0000_0001}});
        carry_case(OP_MAXU, SEW_32, {2{64'h8000_0000_0000_0001}},
                   {2{64'h7FFF_FFFF_FFFF_FFFF}}, {2{64'h8000_0000_FFFF_FFFF}});
    endtask

    task automatic busy_start_ignored();
        vreg_group_t a;
        vreg_group_t b;
        vreg_group_t expected;
        int          pulses;
        rand_group(a);
        rand_group(b);
        expected = ref_group(OP_ADD, SEW_16, LMUL_4, a, b);
        @(posedge clk);
        #2;
        opcode = OP_ADD;
        sew    = SEW_16;
        lmul   = LMUL_4;
        lanes  = LANES_1;
        op_a   = a;
        op_b   = b;
        start  = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        // Second request lands while the first is still issuing
        @(posedge clk);
        #2;
        opcode = OP_XOR;
        sew    = SEW_8;
        op_a   = ~a;
        start  = 1'b1;
        @(posedge clk);
        #2;
        start  = 1'b0;
        pulses = 0;
        repeat (8) begin
            @(posedge clk);
            #1;
            if (done) begin
                pulses++;
            end
        end
        check_eq("done_pulses", 1, pulses);
        check_eq("busy", 0, busy);
        check_eq("result", expected, result);
    endtask

    task automatic clear_on_start();
        vreg_group_t a;
        vreg_group_t b;
        rand_group(a);
        rand_group(b);
        run_op(OP_OR, SEW_32, LMUL_4, LANES_4, a, b);
        rand_group(a);
        rand_group(b);
        run_op(OP_XOR, SEW_8, LMUL_1, LANES_1, a, b);
    endtask

    initial begin
        nrst   = 1'b0;
        start  = 1'b0;
        opcode = OP_ADD;
        sew    = SEW_8;
        lmul   = LMUL_1;
        lanes  = LANES_1;
        op_a   = '0;
        op_b   = '0;
        reset_state_check();
        opcode_sweep();
        geometry_sweep();
        carry_cut_checks();
        busy_start_ignored();
        clear_on_start();
        $display("sim passed");
        $finish;
    end

endmodule

//--- files.f
common/vec_cfg_pkg.sv
common/valu_pkg.sv
common/issue_if.sv
common/lane_result_if.sv
src/issue_sequencer.sv
lanes/valu_slice.sv
lanes/lane_array.sv
src/result_collector.sv
src/vec_lanes_top.sv
testbench/tb_vec_lanes.sv
